//--- design/decode_pkg.sv
package decode_pkg;

    // instruction field widths
    localparam int NB_INSTR    = 32;
    localparam int NB_OP       = 6;
    localparam int NB_FUNCT    = 6;
    localparam int NB_REG_ADDR = 5;
    localparam int NB_SHAMT    = 5;
    localparam int NB_IMM      = 16;
    localparam int NB_JIDX     = 26;

    localparam int N_REGISTER        = 32;
    localparam int DEFAULT_NB_DATA   = 32;
    localparam int DEFAULT_N_CREDITS = 4;

    localparam logic [NB_REG_ADDR-1:0] LINK_REG = 5'd31; // jal return address

    typedef enum logic [NB_OP-1:0] {
        RTYPE = 6'b000000,
        ADDI  = 6'b001000,
        LW    = 6'b100011,
        LWU   = 6'b010011,
        LB    = 6'b100000,
        SH    = 6'b101001,
        SW    = 6'b101011,
        SB    = 6'b101000,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        J     = 6'b110001,
        JAL   = 6'b000011,
        NOP   = 6'b111110,
        HALT  = 6'b111111
    } opcode_e;

    // r-type shifts take their amount from the shamt field
    localparam logic [NB_FUNCT-1:0] funct_sll = 6'b000000;
    localparam logic [NB_FUNCT-1:0] funct_srl = 6'b000010;
    localparam logic [NB_FUNCT-1:0] funct_sra = 6'b000011;

    typedef enum logic [1:0] {
        RT   = 2'b00,
        RD   = 2'b01,
        LINK = 2'b10 // register 31
    } reg_dest_e;

    typedef enum logic [1:0] {
        MEM_DATA   = 2'b00,
        ALU_RESULT = 2'b01,
        PC_LINK    = 2'b10
    } wb_src_e;

    // one-hot access size and zero without a memory access
    typedef enum logic [2:0] {
        MEM_NONE = 3'b000,
        WORD     = 3'b100,
        HALF     = 3'b010,
        BYTE     = 3'b001
    } mem_size_e;

endpackage

//--- design/decode_ctrl_if.sv
`timescale 1ns/1ps

interface decode_ctrl_if
    import decode_pkg::*;
();

    opcode_e   opcode;
    logic      tipe_i;    // second operand is the immediate
    logic      shamt;     // second operand is the shift amount
    logic      beq;
    logic      bne;
    logic      jump;
    reg_dest_e reg_dest;
    logic      mem_sign;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      reg_write;
    wb_src_e   wb_src;
    logic      halt;

    modport decoder (
        output opcode, tipe_i, shamt, beq, bne, jump, reg_dest,
        output mem_sign, mem_read, mem_write, mem_size,
        output reg_write, wb_src, halt
    );

    modport builder (
        input opcode, tipe_i, shamt, beq, bne, jump, reg_dest,
        input mem_sign, mem_read, mem_write, mem_size,
        input reg_write, wb_src, halt
    );

endinterface

//--- design/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import decode_pkg::*;
(
    input  logic [NB_OP-1:0]    opcode,
    input  logic [NB_FUNCT-1:0] funct,
    decode_ctrl_if.decoder      ctrl
);

    logic is_shift;

    assign is_shift = (funct == funct_sll) || (funct == funct_srl) || (funct == funct_sra);

    always_comb begin
        // everything off unless the opcode turns it on
        ctrl.opcode    = opcode_e'(opcode);
        ctrl.tipe_i    = 1'b0;
        ctrl.shamt     = 1'b0;
        ctrl.beq       = 1'b0;
        ctrl.bne       = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.reg_dest  = RT;
        ctrl.mem_sign  = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.mem_size  = MEM_NONE;
        ctrl.reg_write = 1'b0;
        ctrl.wb_src    = MEM_DATA;
        ctrl.halt      = 1'b0;

        case (opcode_e'(opcode))
            RTYPE: begin
                ctrl.shamt     = is_shift;
                ctrl.reg_dest  = RD;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = ALU_RESULT;
            end
            ADDI: begin
                ctrl.tipe_i    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = ALU_RESULT;
            end
            LW, LWU, LB: begin
                ctrl.tipe_i    = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.mem_sign  = (opcode_e'(opcode) != LWU); // lwu zero-extends
                ctrl.mem_size  = (opcode_e'(opcode) == LB) ? BYTE : WORD;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = MEM_DATA;
            end
            SB: begin
                ctrl.tipe_i    = 1'b1; // base plus offset
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = BYTE;
            end
            SH: begin
                ctrl.tipe_i    = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = HALF;
            end
            SW: begin
                ctrl.tipe_i    = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = WORD;
            end
            BEQ: begin
                ctrl.tipe_i = 1'b1;
                ctrl.beq    = 1'b1;
            end
            BNE: begin
                ctrl.tipe_i = 1'b1;
                ctrl.bne    = 1'b1;
            end
            J: begin
                ctrl.jump = 1'b1;
            end
            JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_dest  = LINK;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = PC_LINK;
            end
            HALT: begin
                ctrl.halt = 1'b1;
            end
            NOP: begin
            end
            default: begin
                ctrl.opcode = NOP; // unknown opcode travels on as a no-op
            end
        endcase
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file
    import decode_pkg::*;
#(
    parameter int NB_DATA = DEFAULT_NB_DATA
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [NB_REG_ADDR-1:0] rs_addr,
    input  logic [NB_REG_ADDR-1:0] rt_addr,
    output logic [NB_DATA-1:0]     rs_data,
    output logic [NB_DATA-1:0]     rt_data,
    input  logic                   wb_we,
    input  logic [NB_REG_ADDR-1:0] wb_addr,
    input  logic [NB_DATA-1:0]     wb_data
);

    logic [NB_DATA-1:0] regs [N_REGISTER];
    logic               wb_active;

    // register 0 is never written, so it stays zero after reset
    assign wb_active = wb_we && (wb_addr != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N_REGISTER; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign rs_data = (wb_active && (wb_addr == rs_addr)) ? wb_data : regs[rs_addr];
    assign rt_data = (wb_active && (wb_addr == rt_addr)) ? wb_data : regs[rt_addr];

endmodule

//--- design/decode_bundle_builder.sv
`timescale 1ns/1ps

module decode_bundle_builder
    import decode_pkg::*;
#(
    parameter int NB_DATA   = DEFAULT_NB_DATA,
    parameter int N_CREDITS = DEFAULT_N_CREDITS
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [NB_INSTR-1:0]    instr,
    input  logic [NB_DATA-1:0]     instr_pc,
    decode_ctrl_if.builder         ctrl,
    input  logic [NB_DATA-1:0]     rs_data,
    input  logic [NB_DATA-1:0]     rt_data,
    input  logic                   credit_return,
    output logic                   instr_ready,
    output logic                   out_valid,
    output opcode_e                out_opcode,
    output logic [NB_DATA-1:0]     out_rs_data,
    output logic [NB_DATA-1:0]     out_rt_data,
    output logic [NB_DATA-1:0]     out_imm,
    output logic [NB_SHAMT-1:0]    out_shamt,
    output logic                   out_use_imm,
    output logic                   out_use_shamt,
    output logic [NB_REG_ADDR-1:0] out_dest,
    output logic                   out_mem_sign,
    output logic                   out_mem_read,
    output logic                   out_mem_write,
    output mem_size_e              out_mem_size,
    output logic                   out_reg_write,
    output wb_src_e                out_wb_src,
    output logic                   out_halt,
    output logic                   branch_taken,
    output logic [NB_DATA-1:0]     branch_target
);

    localparam int NB_CREDIT = $clog2(N_CREDITS + 1);

    logic [NB_CREDIT-1:0]   credit_cnt;
    logic                   accept;
    logic [NB_REG_ADDR-1:0] rt_field;
    logic [NB_REG_ADDR-1:0] rd_field;
    logic [NB_IMM-1:0]      imm_field;
    logic [NB_JIDX-1:0]     jidx_field;
    logic [NB_DATA-1:0]     imm_ext;
    logic [NB_DATA-1:0]     pc_plus4;
    logic [NB_REG_ADDR-1:0] dest;
    logic                   taken;
    logic [NB_DATA-1:0]     target;

    assign instr_ready = (credit_cnt != '0); // count never goes below zero
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            credit_cnt <= NB_CREDIT'(N_CREDITS);
        end else if (accept && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_return && !accept) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    assign rt_field   = instr[16 +: NB_REG_ADDR];
    assign rd_field   = instr[11 +: NB_REG_ADDR];
    assign imm_field  = instr[0 +: NB_IMM];
    assign jidx_field = instr[0 +: NB_JIDX];

    assign imm_ext  = {{(NB_DATA-NB_IMM){imm_field[NB_IMM-1]}}, imm_field};
    assign pc_plus4 = instr_pc + NB_DATA'(4);

    always_comb begin
        case (ctrl.reg_dest)
            RD:      dest = rd_field;
            LINK:    dest = LINK_REG;
            default: dest = rt_field;
        endcase
    end

    assign taken = (ctrl.beq && (rs_data == rt_data)) ||
                   (ctrl.bne && (rs_data != rt_data)) ||
                   ctrl.jump;

    always_comb begin
        if (ctrl.jump) begin
            target = {instr_pc[NB_DATA-1:NB_JIDX+2], jidx_field, 2'b00}; // region jump
        end else if (ctrl.beq || ctrl.bne) begin
            target = pc_plus4 + (imm_ext << 2);
        end else begin
            target = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid    <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            out_valid    <= accept;
            branch_taken <= accept && taken; // pulses with out_valid
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_opcode    <= ctrl.opcode;
            out_rs_data   <= rs_data;
            out_rt_data   <= rt_data;
            out_imm       <= imm_ext;
            out_shamt     <= instr[6 +: NB_SHAMT];
            out_use_imm   <= ctrl.tipe_i;
            out_use_shamt <= ctrl.shamt;
            out_dest      <= dest;
            out_mem_sign  <= ctrl.mem_sign;
            out_mem_read  <= ctrl.mem_read;
            out_mem_write <= ctrl.mem_write;
            out_mem_size  <= ctrl.mem_size;
            // branches and halt never write a register
            out_reg_write <= ctrl.reg_write && !ctrl.beq && !ctrl.bne && !ctrl.halt;
            out_wb_src    <= ctrl.wb_src;
            out_halt      <= ctrl.halt;
            branch_target <= target;
        end
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
#(
    parameter int NB_DATA   = DEFAULT_NB_DATA,
    parameter int N_CREDITS = DEFAULT_N_CREDITS
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic [NB_INSTR-1:0]    instr,
    input  logic [NB_DATA-1:0]     instr_pc,
    input  logic                   wb_we,
    input  logic [NB_REG_ADDR-1:0] wb_addr,
    input  logic [NB_DATA-1:0]     wb_data,
    input  logic                   credit_return,
    output logic                   out_valid,
    output opcode_e                out_opcode,
    output logic [NB_DATA-1:0]     out_rs_data,
    output logic [NB_DATA-1:0]     out_rt_data,
    output logic [NB_DATA-1:0]     out_imm,
    output logic [NB_SHAMT-1:0]    out_shamt,
    output logic                   out_use_imm,
    output logic                   out_use_shamt,
    output logic [NB_REG_ADDR-1:0] out_dest,
    output logic                   out_mem_sign,
    output logic                   out_mem_read,
    output logic                   out_mem_write,
    output mem_size_e              out_mem_size,
    output logic                   out_reg_write,
    output wb_src_e                out_wb_src,
    output logic                   out_halt,
    output logic                   branch_taken,
    output logic [NB_DATA-1:0]     branch_target
);

    logic [NB_DATA-1:0] rs_data;
    logic [NB_DATA-1:0] rt_data;

    decode_ctrl_if ctrl_if ();

    control_unit control_unit_i (
        .opcode (instr[NB_INSTR-1 -: NB_OP]),
        .funct  (instr[0 +: NB_FUNCT]),
        .ctrl   (ctrl_if.decoder)
    );

    // rs and rt come straight from the instruction word
    register_file #(
        .NB_DATA (NB_DATA)
    ) register_file_i (
        .clock   (clock),
        .reset   (reset),
        .rs_addr (instr[21 +: NB_REG_ADDR]),
        .rt_addr (instr[16 +: NB_REG_ADDR]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    decode_bundle_builder #(
        .NB_DATA   (NB_DATA),
        .N_CREDITS (N_CREDITS)
    ) decode_bundle_builder_i (
        .clock         (clock),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .ctrl          (ctrl_if.builder),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .credit_return (credit_return),
        .instr_ready   (instr_ready),
        .out_valid     (out_valid),
        .out_opcode    (out_opcode),
        .out_rs_data   (out_rs_data),
        .out_rt_data   (out_rt_data),
        .out_imm       (out_imm),
        .out_shamt     (out_shamt),
        .out_use_imm   (out_use_imm),
        .out_use_shamt (out_use_shamt),
        .out_dest      (out_dest),
        .out_mem_sign  (out_mem_sign),
        .out_mem_read  (out_mem_read),
        .out_mem_write (out_mem_write),
        .out_mem_size  (out_mem_size),
        .out_reg_write (out_reg_write),
        .out_wb_src    (out_wb_src),
        .out_halt      (out_halt),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

//--- test/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// what execute should see for one accepted instruction
typedef struct packed {
    logic [5:0]  opcode;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] imm;
    logic [4:0]  shamt;
    logic        use_imm;
    logic        use_shamt;
    logic [4:0]  dest;
    logic        mem_sign;
    logic        mem_read;
    logic        mem_write;
    logic [2:0]  mem_size;
    logic        reg_write;
    logic [1:0]  wb_src;
    logic        halt;
    logic        taken;
    logic        is_branch;  // target only matters for branches and jumps
    logic [31:0] target;
} bundle_t;

logic [31:0] mirror [32];   // register file contents as writeback leaves them
bundle_t     expected_q [$];
int          outstanding;   // bundles issued and not yet given back

task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
        mirror[i] = '0;
    end
    expected_q.delete();
    outstanding = 0;
endtask

// committing before the read gives the write-through value
task automatic apply_writeback(input logic we, input logic [4:0] addr, input logic [31:0] data);
    if (we && (addr != 5'd0)) begin
        mirror[addr] = data;
    end
endtask

function automatic bundle_t predict_bundle(input logic [31:0] word, input logic [31:0] pc);
    bundle_t    b;
    logic [5:0] op;
    logic [5:0] fn;
    op        = word[31:26];
    fn        = word[5:0];
    b         = '0;
    b.opcode  = op;
    b.rs_data = mirror[word[25:21]];
    b.rt_data = mirror[word[20:16]];
    b.imm     = {{16{word[15]}}, word[15:0]};
    b.shamt   = word[10:6];
    b.dest    = word[20:16];  // rt unless the opcode says otherwise
    if (op == RTYPE) begin
        case (fn)
            funct_sll, funct_srl, funct_sra: b.use_shamt = 1'b1;
            default:                         b.use_shamt = 1'b0;
        endcase
        b.dest      = word[15:11];
        b.reg_write = 1'b1;
        b.wb_src    = ALU_RESULT;
    end else if (op == ADDI) begin
        b.use_imm   = 1'b1;
        b.reg_write = 1'b1;
        b.wb_src    = ALU_RESULT;
    end else if ((op == LW) || (op == LWU) || (op == LB)) begin
        b.use_imm   = 1'b1;
        b.mem_read  = 1'b1;
        b.reg_write = 1'b1;  // wb_src stays MEM_DATA
        if (op == LW) begin
            b.mem_sign = 1'b1;
            b.mem_size = WORD;
        end else if (op == LWU) begin
            b.mem_size = WORD;  // zero-extended word
        end else begin
            b.mem_sign = 1'b1;
            b.mem_size = BYTE;
        end
    end else if ((op == SW) || (op == SH) || (op == SB)) begin
        b.use_imm   = 1'b1;
        b.mem_write = 1'b1;
        if (op == SW) begin
            b.mem_size = WORD;
        end else if (op == SH) begin
            b.mem_size = HALF;
        end else begin
            b.mem_size = BYTE;
        end
    end else if ((op == BEQ) || (op == BNE)) begin
        b.use_imm   = 1'b1;
        b.is_branch = 1'b1;
        if (op == BEQ) begin
            b.taken = (b.rs_data == b.rt_data);
        end else begin
            b.taken = (b.rs_data != b.rt_data);
        end
        b.target = pc + 32'd4 + (b.imm << 2);
    end else if ((op == J) || (op == JAL)) begin
        b.is_branch = 1'b1;
        b.taken     = 1'b1;
        b.target    = {pc[31:28], word[25:0], 2'b00};
        if (op == JAL) begin
            b.dest      = 5'd31;
            b.reg_write = 1'b1;
            b.wb_src    = PC_LINK;
        end
    end else if (op == HALT) begin
        b.halt = 1'b1;
    end else if (op != NOP) begin
        b.opcode = NOP;  // unknown opcode leaves every control zero
    end
    return b;
endfunction

`endif

//--- test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
();

    localparam int         N_CREDITS   = 4;
    localparam int         STIM_CYCLES = 180;  // all tests without credit stalls
    localparam int         MAX_CYCLES  = 4 * STIM_CYCLES + 100;
    localparam logic [5:0] FUNCT_ADD   = 6'b100000;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        credit_return;
    logic        out_valid;
    opcode_e     out_opcode;
    logic [31:0] out_rs_data;
    logic [31:0] out_rt_data;
    logic [31:0] out_imm;
    logic [4:0]  out_shamt;
    logic        out_use_imm;
    logic        out_use_shamt;
    logic [4:0]  out_dest;
    logic        out_mem_sign;
    logic        out_mem_read;
    logic        out_mem_write;
    mem_size_e   out_mem_size;
    logic        out_reg_write;
    wb_src_e     out_wb_src;
    logic        out_halt;
    logic        branch_taken;
    logic [31:0] branch_target;

    int    seed = 49;
    int    cycle_cnt = 0;
    int    checks = 0;
    int    errors = 0;
    int    errors_before = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    bundles = 0;
    string test_name;
    logic  held = 1'b0;      // fetch keeps its word while it is not accepted
    logic  withhold = 1'b0;  // execute keeps its credits

    opcode_e    legal_ops [14] = '{RTYPE, ADDI, LW, LWU, LB, SH, SW, SB,
                                   BEQ, BNE, J, JAL, NOP, HALT};
    logic [5:0] illegal_ops [3] = '{6'b000001, 6'b010101, 6'b111000};

    `include "decode_model.svh"

    decode_stage #(
        .NB_DATA   (32),
        .N_CREDITS (N_CREDITS)
    ) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Error: run still going after %0d cycles, stopped", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic flag_failure(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic verify_outputs();
        bundle_t e;
        compare_field("instr_ready", instr_ready, outstanding < N_CREDITS);
        if (out_valid) begin
            flag_failure(expected_q.size() > 0, "bundle appeared with no instruction accepted");
        end else begin
            compare_field("branch_taken", branch_taken, 1'b0);
        end
        if (out_valid && (expected_q.size() > 0)) begin
            e = expected_q.pop_front();
            bundles++;
            compare_field("out_opcode", out_opcode, e.opcode);
            compare_field("out_rs_data", out_rs_data, e.rs_data);
            compare_field("out_rt_data", out_rt_data, e.rt_data);
            compare_field("out_imm", out_imm, e.imm);
            compare_field("out_shamt", out_shamt, e.shamt);
            compare_field("out_use_imm", out_use_imm, e.use_imm);
            compare_field("out_use_shamt", out_use_shamt, e.use_shamt);
            compare_field("out_dest", out_dest, e.dest);
            compare_field("out_mem_sign", out_mem_sign, e.mem_sign);
            compare_field("out_mem_read", out_mem_read, e.mem_read);
            compare_field("out_mem_write", out_mem_write, e.mem_write);
            compare_field("out_mem_size", out_mem_size, e.mem_size);
            compare_field("out_reg_write", out_reg_write, e.reg_write);
            compare_field("out_wb_src", out_wb_src, e.wb_src);
            compare_field("out_halt", out_halt, e.halt);
            compare_field("branch_taken", branch_taken, e.taken);
            if (e.is_branch) begin
                compare_field("branch_target", branch_target, e.target);
            end
        end
        // each bundle is due exactly one cycle after its accept
        flag_failure(expected_q.size() == 0, "accepted instruction gave no bundle a cycle later");
        expected_q.delete();
    endtask

    // outputs are sampled mid-cycle and inputs move 10 ns after the edge
    task automatic run_cycle();
        @(negedge clock);
        verify_outputs();
        apply_writeback(wb_we, wb_addr, wb_data);
        held = instr_valid && !instr_ready;
        if (instr_valid && instr_ready) begin
            expected_q.push_back(predict_bundle(instr, instr_pc));
            outstanding++;
        end
        if (credit_return) begin
            outstanding--;
        end
        @(posedge clock);
        #10;
        wb_we = 1'b0;
    endtask

    task automatic drive_credit();
        credit_return = !withhold && (outstanding > 0) && (($random(seed) & 1) != 0);
    endtask

    task automatic issue(input logic [31:0] word);
        if (!held) begin
            instr    = word;
            instr_pc = $random(seed) & 32'hffff_fffc;
        end
        instr_valid = 1'b1;
        do begin
            drive_credit();
            run_cycle();
        end while (held);
    endtask

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) begin
            drive_credit();
            run_cycle();
        end
    endtask

    task automatic drain_credits();
        instr_valid = 1'b0;
        while (outstanding > 0) begin
            credit_return = 1'b1;
            run_cycle();
        end
        credit_return = 1'b0;
    endtask

    function automatic logic [4:0] random_reg();
        return 5'($random(seed));
    endfunction

    function automatic logic [31:0] encode_instr(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] low);
        return {op, rs, rt, low};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int          pick;
        w    = $random(seed);
        pick = {$random(seed)} % 17;
        if (pick < 14) begin
            w[31:26] = legal_ops[pick];
        end else begin
            w[31:26] = illegal_ops[pick - 14];
        end
        if (w[31:26] == RTYPE) begin
            case ({$random(seed)} % 4)
                0:       w[5:0] = funct_sll;
                1:       w[5:0] = funct_srl;
                2:       w[5:0] = funct_sra;
                default: w[5:0] = FUNCT_ADD;
            endcase
        end
        return w;
    endfunction

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] va;
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        instr_pc      = '0;
        wb_we         = 1'b0;
        wb_addr       = '0;
        wb_data       = '0;
        credit_return = 1'b0;
        clear_model();
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;

        begin_test("reset state");
        compare_field("out_valid", out_valid, 1'b0);
        compare_field("branch_taken", branch_taken, 1'b0);
        compare_field("instr_ready", instr_ready, 1'b1);
        repeat (4) issue(encode_instr(RTYPE, random_reg(), random_reg(), 16'($random(seed))));
        idle(2);
        end_test();

        begin_test("decode table");
        for (int i = 0; i < 14; i++) begin
            issue(encode_instr(legal_ops[i], random_reg(), random_reg(), 16'($random(seed))));
        end
        for (int i = 0; i < 3; i++) begin
            issue(encode_instr(illegal_ops[i], random_reg(), random_reg(), 16'($random(seed))));
        end
        issue(encode_instr(RTYPE, random_reg(), random_reg(), {10'($random(seed)), funct_sll}));
        issue(encode_instr(RTYPE, random_reg(), random_reg(), {10'($random(seed)), funct_srl}));
        issue(encode_instr(RTYPE, random_reg(), random_reg(), {10'($random(seed)), funct_sra}));
        issue(encode_instr(RTYPE, random_reg(), random_reg(), {10'($random(seed)), FUNCT_ADD}));
        repeat (80) begin
            wb_we   = 1'($random(seed));
            wb_addr = random_reg();
            wb_data = $random(seed);
            issue(random_word());
        end
        idle(4);
        end_test();

        begin_test("register file");
        drain_credits();
        ra      = 5'(({$random(seed)} % 31) + 1);
        wb_we   = 1'b1;
        wb_addr = ra;
        wb_data = $random(seed);
        idle(1);
        issue(encode_instr(ADDI, ra, 5'd0, 16'h0004));  // read after write
        rb      = 5'(({$random(seed)} % 31) + 1);
        wb_we   = 1'b1;
        wb_addr = rb;
        wb_data = $random(seed);
        issue(encode_instr(RTYPE, rb, ra, {5'd1, 5'd0, FUNCT_ADD}));  // same cycle
        wb_we   = 1'b1;
        wb_addr = 5'd0;
        wb_data = 32'hffff_ffff;
        idle(1);
        issue(encode_instr(RTYPE, 5'd0, 5'd0, {5'd2, 5'd0, FUNCT_ADD}));
        wb_we   = 1'b1;
        wb_addr = 5'd0;
        wb_data = 32'h1234_5678;
        issue(encode_instr(RTYPE, 5'd0, ra, {5'd3, 5'd0, FUNCT_ADD}));  // r0 same cycle
        idle(2);
        end_test();

        begin_test("branch resolution");
        drain_credits();
        ra      = 5'(({$random(seed)} % 15) + 1);
        rb      = ra + 5'd16;
        va      = $random(seed);
        wb_we   = 1'b1;
        wb_addr = ra;
        wb_data = va;
        idle(1);
        wb_we   = 1'b1;
        wb_addr = rb;
        wb_data = ~va;
        idle(1);
        issue(encode_instr(BEQ, ra, ra, 16'($random(seed))));  // taken
        issue(encode_instr(BEQ, ra, rb, 16'($random(seed))));
        issue(encode_instr(BNE, ra, rb, 16'($random(seed))));  // taken
        issue(encode_instr(BNE, rb, rb, 16'($random(seed))));
        issue(encode_instr(J, random_reg(), random_reg(), 16'($random(seed))));
        issue(encode_instr(JAL, random_reg(), random_reg(), 16'($random(seed))));
        idle(3);
        end_test();

        begin_test("credit flow");
        drain_credits();
        withhold    = 1'b1;
        bundles     = 0;
        instr_valid = 1'b1;
        repeat (N_CREDITS + 4) begin
            if (!held) begin
                instr    = encode_instr(ADDI, random_reg(), random_reg(), 16'($random(seed)));
                instr_pc = $random(seed) & 32'hffff_fffc;
            end
            credit_return = 1'b0;
            run_cycle();
        end
        compare_field("bundles without credit", bundles, N_CREDITS);
        flag_failure(held, "fetch was not held off after all credits were spent");
        withhold = 1'b0;
        repeat (6) issue(random_word());  // first one is the stalled word
        idle(4);
        end_test();

        begin_test("loads and stores");
        for (int i = 2; i < 8; i++) begin  // lw through sb in legal_ops
            issue(encode_instr(legal_ops[i], random_reg(), random_reg(), 16'($random(seed))));
        end
        idle(4);
        end_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+test
design/decode_pkg.sv
design/decode_ctrl_if.sv
design/control_unit.sv
design/register_file.sv
design/decode_bundle_builder.sv
design/decode_stage.sv
test/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/decode_pkg.sv
  - design/decode_ctrl_if.sv
  - design/control_unit.sv
  - design/register_file.sv
  - design/decode_bundle_builder.sv
  - design/decode_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/decode_stage_tb.sv
